// ==== verilog/cdPkg.sv ====
// CD-ROM controller package with FIFO depths, bus addresses and audio types
package cdPkg;

	// ------------------------------------------------------------------
	// FIFO sizes
	// ------------------------------------------------------------------
	localparam int PARAM_FIFO_DEPTH = 16;
	localparam int RESP_FIFO_DEPTH  = 16;
	// Sector data buffer, drive side fills it
	localparam int DATA_FIFO_DEPTH  = 32;

	// ------------------------------------------------------------------
	// Bus addresses, meaning further split by the index register
	// ------------------------------------------------------------------
	// Index and status
	localparam logic [1:0] ADR_STATUS = 2'd0;
	// Command write, response read
	localparam logic [1:0] ADR_CMD    = 2'd1;
	// Parameter write, data read
	localparam logic [1:0] ADR_PARAM  = 2'd2;
	// Interrupt and volume registers
	localparam logic [1:0] ADR_EXTRA  = 2'd3;

	// Volume 80h is unity gain
	localparam int VOL_SHIFT = 7;

	// Signed audio sample
	typedef logic signed [15:0] cdSample_t;

	// Source channel first, destination second
	typedef struct packed {
		logic [7:0] ll;
		logic [7:0] lr;
		logic [7:0] rl;
		logic [7:0] rr;
	} cdVolume_t;

endpackage

// ==== verilog/cdFifoIf.sv ====
// Byte FIFO bundle with push, pop, clear, head data and fill flags
`timescale 1ns/1ns

interface cdFifoIf;

	// Write side
	logic       push;
	logic [7:0] wrData;
	// Read side
	logic       pop;
	logic       clear;
	// Head of queue and flags from the store
	logic [7:0] rdData;
	logic       empty;
	logic       full;

	modport writer (output push, output wrData);

	modport reader (output pop, output clear, input rdData, input empty, input full);

	// Clear only, for a controller that does not pop
	modport readerClr (output clear);

	modport store (input push, input wrData, input pop, input clear,
		output rdData, output empty, output full);

endinterface

// ==== verilog/cdByteFifo.sv ====
// Byte FIFO, first word fall through, with synchronous clear
`timescale 1ns/1ns

module cdByteFifo #(
	parameter int DEPTH = 16
) (
	input  logic    i_clk,
	input  logic    i_nrst,
	cdFifoIf.store  io_fifo
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Storage, contents undefined until written
	logic [7:0]       mem [DEPTH];
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W-1:0] wrPtr;
	logic [CNT_W-1:0] count;

	logic doPush;
	logic doPop;

	// Push while full and pop while empty are dropped
	assign doPush = io_fifo.push && !io_fifo.full;
	assign doPop  = io_fifo.pop && !io_fifo.empty;

	// Head always visible
	assign io_fifo.rdData = mem[rdPtr];
	assign io_fifo.empty  = (count == '0);
	assign io_fifo.full   = (count == CNT_W'(DEPTH));

	// Pointer step with wrap for any depth
	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		nextPtr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge i_clk) begin
		if (!i_nrst || io_fifo.clear) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (doPop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			// Push and pop together leave count alone
			if (doPush && !doPop) begin
				count <= count + 1'b1;
			end else if (doPop && !doPush) begin
				count <= count - 1'b1;
			end
		end
	end

	// Data write port
	always_ff @(posedge i_clk) begin
		if (doPush) begin
			mem[wrPtr] <= io_fifo.wrData;
		end
	end

	// Occupancy bound over the whole run
	assert property (@(posedge i_clk) disable iff (!i_nrst) count <= CNT_W'(DEPTH));

endmodule

// ==== verilog/cdRegControl.sv ====
// CD-ROM register block with index decode, read mux, FIFO steering, volumes and IRQ
`timescale 1ns/1ns

module cdRegControl
	import cdPkg::*;
(
	input  logic       i_clk,
	input  logic       i_nrst,
	// CPU bus
	input  logic       i_CDROM_CS,
	input  logic       i_write,
	input  logic [1:0] i_adr,
	input  logic [7:0] i_dataIn,
	output logic [7:0] o_dataOut,
	// Parameter FIFO, written here, popped by the drive
	cdFifoIf.writer    io_param,
	cdFifoIf.readerClr io_paramClr,
	input  logic       i_paramEmpty,
	input  logic       i_paramFull,
	// Response and sector data FIFOs, drained here
	cdFifoIf.reader    io_resp,
	cdFifoIf.reader    io_data,
	// Drive command
	output logic       o_cmdStrobe,
	output logic [7:0] o_cmdByte,
	// Interrupts
	input  logic       i_irqStrobe,
	input  logic [2:0] i_irqCode,
	output logic       o_irq,
	// Volumes in use by the mixer
	output cdVolume_t  o_volWork
);

	logic [1:0] idxReg;
	cdVolume_t  volPend;
	cdVolume_t  volWork;
	logic [4:0] intEnable;
	// Bits above the enable, stored and read back only
	logic [2:0] intStored;
	logic [2:0] irqFlag;
	logic [7:0] lastData;

	logic       busWr;
	logic       busRd;
	logic       issueCmd;
	logic       ackFlag;
	logic       applyVol;
	logic [7:0] statusByte;
	logic [7:0] respByte;
	logic [7:0] dataByte;
	logic [7:0] readMux;

	// ------------------------------------------------------------------
	// Bus decode
	// ------------------------------------------------------------------
	assign busWr    = i_CDROM_CS && i_write;
	assign busRd    = i_CDROM_CS && !i_write;
	assign issueCmd = busWr && (i_adr == ADR_CMD) && (idxReg == 2'd0);
	assign ackFlag  = busWr && (i_adr == ADR_EXTRA) && (idxReg == 2'd1) && (&i_dataIn[2:0]);
	assign applyVol = busWr && (i_adr == ADR_EXTRA) && (idxReg == 2'd3) && i_dataIn[5];

	// Parameter push and reset
	assign io_param.push     = busWr && (i_adr == ADR_PARAM) && (idxReg == 2'd0);
	assign io_param.wrData   = i_dataIn;
	assign io_paramClr.clear = busWr && (i_adr == ADR_EXTRA) && (idxReg == 2'd1) && i_dataIn[6];

	// Reads pop the FIFO at the same edge the head is captured
	assign io_resp.pop   = busRd && (i_adr == ADR_CMD);
	assign io_resp.clear = 1'b0;
	assign io_data.pop   = busRd && (i_adr == ADR_PARAM);
	assign io_data.clear = 1'b0;

	// ------------------------------------------------------------------
	// Write registers
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			idxReg    <= 2'd0;
			volPend   <= '0;
			volWork   <= '0;
			intEnable <= 5'd0;
			intStored <= 3'd0;
		end else begin
			if (busWr) begin
				case (i_adr)
				ADR_STATUS: idxReg <= i_dataIn[1:0];
				// Index 0 is the command, handled below
				ADR_CMD: if (idxReg == 2'd3) volPend.rr <= i_dataIn;
				ADR_PARAM: begin
					case (idxReg)
					2'd1: begin
						intEnable <= i_dataIn[4:0];
						intStored <= i_dataIn[7:5];
					end
					2'd2: volPend.ll <= i_dataIn;
					2'd3: volPend.rl <= i_dataIn;
					default: ;
					endcase
				end
				// Index 1 ack and index 3 apply are decoded above
				ADR_EXTRA: if (idxReg == 2'd2) volPend.lr <= i_dataIn;
				default: ;
				endcase
			end
			// Copy pending set into the working set
			if (applyVol) begin
				volWork <= volPend;
			end
		end
	end

	// Interrupt flag, a new code wins over an ack in the same cycle
	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			irqFlag <= 3'd0;
		end else if (i_irqStrobe) begin
			irqFlag <= i_irqCode;
		end else if (ackFlag) begin
			irqFlag <= 3'd0;
		end
	end

	assign o_irq     = |(irqFlag & intEnable[2:0]);
	assign o_volWork = volWork;

	// Command strobe one cycle after the write
	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			o_cmdStrobe <= 1'b0;
		end else begin
			o_cmdStrobe <= issueCmd;
		end
	end

	always_ff @(posedge i_clk) begin
		if (issueCmd) begin
			o_cmdByte <= i_dataIn;
		end
	end

	// ------------------------------------------------------------------
	// Read side
	// ------------------------------------------------------------------
	// Busy and ADPCM bits stay zero
	assign statusByte = {1'b0, !io_data.empty, !io_resp.empty, !i_paramFull,
		i_paramEmpty, 1'b0, idxReg};

	// Empty response reads zero, empty data repeats the last byte
	assign respByte = io_resp.empty ? 8'h00 : io_resp.rdData;
	assign dataByte = io_data.empty ? lastData : io_data.rdData;

	always_comb begin
		case (i_adr)
		ADR_STATUS: readMux = statusByte;
		ADR_CMD:    readMux = respByte;
		ADR_PARAM:  readMux = dataByte;
		default:    readMux = idxReg[0] ? {3'b111, 2'b00, irqFlag} : {intStored, intEnable};
		endcase
	end

	// Output holds until the next read
	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			o_dataOut <= 8'h00;
			lastData  <= 8'h00;
		end else if (busRd) begin
			o_dataOut <= readMux;
			if (i_adr == ADR_PARAM) begin
				lastData <= dataByte;
			end
		end
	end

	// Single cycle command pulse
	assert property (@(posedge i_clk) disable iff (!i_nrst) o_cmdStrobe |=> !o_cmdStrobe);

	// Software must check status before pushing parameters
	assert property (@(posedge i_clk) disable iff (!i_nrst) !(io_param.push && i_paramFull));

endmodule

// ==== verilog/cdVolumeMixer.sv ====
// CD audio volume matrix, mixes left and right input into both outputs with saturation
`timescale 1ns/1ns

module cdVolumeMixer
	import cdPkg::*;
(
	input  logic      i_clk,
	input  logic      i_nrst,
	input  logic      i_sampleStrobe,
	input  cdSample_t i_cdInL,
	input  cdSample_t i_cdInR,
	input  cdVolume_t i_vol,
	output cdSample_t o_outL,
	output cdSample_t o_outR,
	output logic      o_outputL,
	output logic      o_outputR
);

	cdSample_t mixL;
	cdSample_t mixR;

	// Two weighted inputs, scaled back and clipped to 16 bits
	function automatic cdSample_t mixChannel(
		input cdSample_t a, input logic [7:0] volA,
		input cdSample_t b, input logic [7:0] volB);
		logic signed [25:0] sum;
		logic signed [18:0] scaled;
		// Volumes are unsigned, extended with a zero sign bit
		sum    = a * $signed({1'b0, volA}) + b * $signed({1'b0, volB});
		scaled = 19'(sum >>> VOL_SHIFT);
		if (scaled > 19'sd32767) begin
			mixChannel = 16'sh7FFF;
		end else if (scaled < -19'sd32768) begin
			mixChannel = 16'sh8000;
		end else begin
			mixChannel = scaled[15:0];
		end
	endfunction

	assign mixL = mixChannel(i_cdInL, i_vol.ll, i_cdInR, i_vol.rl);
	assign mixR = mixChannel(i_cdInL, i_vol.lr, i_cdInR, i_vol.rr);

	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			o_outL    <= '0;
			o_outR    <= '0;
			o_outputL <= 1'b0;
			o_outputR <= 1'b0;
		end else begin
			// Both channels valid for one cycle
			o_outputL <= i_sampleStrobe;
			o_outputR <= i_sampleStrobe;
			if (i_sampleStrobe) begin
				o_outL <= mixL;
				o_outR <= mixR;
			end
		end
	end

	// Sound unit expects both channels together
	assert property (@(posedge i_clk) disable iff (!i_nrst) o_outputL == o_outputR);

endmodule

// ==== verilog/CDRom.sv ====
// CD-ROM controller top level, CPU bus, drive side FIFOs and audio mixer
`timescale 1ns/1ns

module CDRom
	import cdPkg::*;
(
	input  logic       i_clk,
	input  logic       i_nrst,
	// CPU side
	input  logic       i_CDROM_CS,
	input  logic       i_write,
	input  logic [1:0] i_adr,
	input  logic [7:0] i_dataIn,
	output logic [7:0] o_dataOut,
	// Drive side
	output logic       o_cmdStrobe,
	output logic [7:0] o_cmdByte,
	output logic [7:0] o_paramByte,
	output logic       o_paramEmpty,
	input  logic       i_paramPop,
	input  logic       i_respPush,
	input  logic [7:0] i_respByte,
	input  logic       i_sectorPush,
	input  logic [7:0] i_sectorByte,
	input  logic       i_irqStrobe,
	input  logic [2:0] i_irqCode,
	output logic       o_irq,
	// Sound unit side
	input  logic       i_sampleStrobe,
	input  cdSample_t  i_cdInL,
	input  cdSample_t  i_cdInR,
	output cdSample_t  o_CDRomOutL,
	output cdSample_t  o_CDRomOutR,
	output logic       o_outputL,
	output logic       o_outputR
);

	cdFifoIf paramIf ();
	cdFifoIf respIf ();
	cdFifoIf dataIf ();

	cdVolume_t volWork;

	// ------------------------------------------------------------------
	// Drive side FIFO ends
	// ------------------------------------------------------------------
	assign paramIf.pop   = i_paramPop;
	assign o_paramByte   = paramIf.rdData;
	assign o_paramEmpty  = paramIf.empty;
	assign respIf.push   = i_respPush;
	assign respIf.wrData = i_respByte;
	assign dataIf.push   = i_sectorPush;
	assign dataIf.wrData = i_sectorByte;

	cdRegControl u_control (
		.i_clk, .i_nrst,
		.i_CDROM_CS, .i_write, .i_adr, .i_dataIn, .o_dataOut,
		.io_param     (paramIf.writer),
		.io_paramClr  (paramIf.readerClr),
		.i_paramEmpty (paramIf.empty),
		.i_paramFull  (paramIf.full),
		.io_resp      (respIf.reader),
		.io_data      (dataIf.reader),
		.o_cmdStrobe, .o_cmdByte,
		.i_irqStrobe, .i_irqCode, .o_irq,
		.o_volWork    (volWork)
	);

	cdByteFifo #(.DEPTH(PARAM_FIFO_DEPTH)) u_paramFifo (.i_clk, .i_nrst, .io_fifo(paramIf.store));
	cdByteFifo #(.DEPTH(RESP_FIFO_DEPTH))  u_respFifo  (.i_clk, .i_nrst, .io_fifo(respIf.store));
	cdByteFifo #(.DEPTH(DATA_FIFO_DEPTH))  u_dataFifo  (.i_clk, .i_nrst, .io_fifo(dataIf.store));

	// Audio path towards the sound unit
	cdVolumeMixer u_mixer (
		.i_clk, .i_nrst,
		.i_sampleStrobe, .i_cdInL, .i_cdInR,
		.i_vol     (volWork),
		.o_outL    (o_CDRomOutL),
		.o_outR    (o_CDRomOutR),
		.o_outputL, .o_outputR
	);

endmodule

// ==== test/tbCDRom.sv ====
// Testbench for the CD-ROM controller with bus tasks, a reference model and assertion checks
`timescale 1ns/1ns

module tbCDRom
	import cdPkg::*;
();

	// ------------------------------------------------------------------
	// Clock period and cycle budgets per test
	// ------------------------------------------------------------------
	localparam int CLK_PERIOD  = 40;
	localparam int RST_CYCLES  = 4;
	localparam int BUDGET_SUM  = RST_CYCLES + 20 + 60 + 10 + 60 + 80 + 120;
	localparam int WATCHDOG_NS = 2 * BUDGET_SUM * CLK_PERIOD;

	logic       i_clk;
	logic       i_nrst;
	logic       i_CDROM_CS;
	logic       i_write;
	logic [1:0] i_adr;
	logic [7:0] i_dataIn;
	logic [7:0] o_dataOut;
	logic       o_cmdStrobe;
	logic [7:0] o_cmdByte;
	logic [7:0] o_paramByte;
	logic       o_paramEmpty;
	logic       i_paramPop;
	logic       i_respPush;
	logic [7:0] i_respByte;
	logic       i_sectorPush;
	logic [7:0] i_sectorByte;
	logic       i_irqStrobe;
	logic [2:0] i_irqCode;
	logic       o_irq;
	logic       i_sampleStrobe;
	cdSample_t  i_cdInL;
	cdSample_t  i_cdInR;
	cdSample_t  o_CDRomOutL;
	cdSample_t  o_CDRomOutR;
	logic       o_outputL;
	logic       o_outputR;

	// Reference model state
	logic [7:0] paramQ[$];
	logic [7:0] respQ[$];
	logic [7:0] dataQ[$];
	logic [1:0] modelIdx;
	cdVolume_t  volPend;
	cdVolume_t  volWork;
	logic [4:0] modelEn;
	logic [2:0] modelStored;
	logic [2:0] modelFlag;
	logic [7:0] lastData;
	cdSample_t  expL;
	cdSample_t  expR;
	logic [31:0] lcgState;
	int passCnt;
	int failCnt;
	int failStart;
	logic cmdWrite;

	CDRom dut_i (.*);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	// Bus write to the command address at index 0
	assign cmdWrite = i_CDROM_CS && i_write && (i_adr == ADR_CMD) && (modelIdx == 2'd0);

	// ------------------------------------------------------------------
	// Concurrent checks
	// ------------------------------------------------------------------
	assert property (@(posedge i_clk) disable iff (!i_nrst) cmdWrite |=> o_cmdStrobe)
	else begin
		failCnt++;
		$display("Command strobe missing after a command write");
	end

	assert property (@(posedge i_clk) disable iff (!i_nrst) !cmdWrite |=> !o_cmdStrobe)
	else begin
		failCnt++;
		$display("Command strobe raised without a command write");
	end

	// Both valid pulses one cycle after the strobe
	assert property (@(posedge i_clk) disable iff (!i_nrst)
		i_sampleStrobe |=> (o_outputL && o_outputR))
	else begin
		failCnt++;
		$display("Mixer valid pulses missing one cycle after the sample strobe");
	end

	// LCG step returning upper state bits
	function automatic logic [7:0] randByte();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		randByte = lcgState[23:16];
	endfunction

	function automatic logic [15:0] randWord();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		randWord = lcgState[31:16];
	endfunction

	// Weighted sum scaled by 2^-7 and clipped to 16 bits signed
	function automatic cdSample_t mixModel(input cdSample_t a, input logic [7:0] va,
		input cdSample_t b, input logic [7:0] vb);
		int sum;
		sum = int'(a) * int'(va) + int'(b) * int'(vb);
		sum = sum >>> VOL_SHIFT;
		if (sum > 32767) begin
			mixModel = 16'sh7FFF;
		end else if (sum < -32768) begin
			mixModel = 16'sh8000;
		end else begin
			mixModel = sum[15:0];
		end
	endfunction

	function automatic logic [7:0] statusModel();
		statusModel = {1'b0, dataQ.size() != 0, respQ.size() != 0,
			paramQ.size() != PARAM_FIFO_DEPTH, paramQ.size() == 0, 1'b0, modelIdx};
	endfunction

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) passCnt++;
		else begin
			failCnt++;
			$display("Mismatch %s: got %0h, expected %0h", name, got, exp);
		end
	endtask

	task automatic endTest(input string name);
		$display("%s finished with %0d errors", name, failCnt - failStart);
		failStart = failCnt;
	endtask

	// ------------------------------------------------------------------
	// Stimulus tasks entered and left at a falling edge
	// ------------------------------------------------------------------
	task automatic busWrite(input logic [1:0] adr, input logic [7:0] data);
		i_CDROM_CS = 1'b1;
		i_write    = 1'b1;
		i_adr      = adr;
		i_dataIn   = data;
		// Model follows the register map
		case (adr)
		ADR_STATUS: modelIdx = data[1:0];
		ADR_CMD: if (modelIdx == 2'd3) volPend.rr = data;
		ADR_PARAM: begin
			if (modelIdx == 2'd0 && paramQ.size() < PARAM_FIFO_DEPTH) paramQ.push_back(data);
			if (modelIdx == 2'd1) {modelStored, modelEn} = data;
			if (modelIdx == 2'd2) volPend.ll = data;
			if (modelIdx == 2'd3) volPend.rl = data;
		end
		default: begin
			if (modelIdx == 2'd1 && data[2:0] == 3'b111) modelFlag = 3'd0;
			if (modelIdx == 2'd1 && data[6]) paramQ.delete();
			if (modelIdx == 2'd2) volPend.lr = data;
			if (modelIdx == 2'd3 && data[5]) volWork = volPend;
		end
		endcase
		@(negedge i_clk);
		i_CDROM_CS = 1'b0;
		i_write    = 1'b0;
	endtask

	task automatic busRead(input logic [1:0] adr, output logic [7:0] data);
		i_CDROM_CS = 1'b1;
		i_write    = 1'b0;
		i_adr      = adr;
		@(negedge i_clk);
		i_CDROM_CS = 1'b0;
		data = o_dataOut;
	endtask

	// Read checked against the model
	// FIFO reads also pop the model queue
	task automatic readCheck(input logic [1:0] adr, input string name, output logic [7:0] got);
		logic [7:0] exp;
		case (adr)
		ADR_STATUS: exp = statusModel();
		ADR_CMD: exp = (respQ.size() != 0) ? respQ.pop_front() : 8'h00;
		ADR_PARAM: begin
			if (dataQ.size() != 0) lastData = dataQ.pop_front();
			exp = lastData;
		end
		default: exp = modelIdx[0] ? {5'b11100, modelFlag} : {modelStored, modelEn};
		endcase
		busRead(adr, got);
		checkVal(name, got, exp);
	endtask

	// Drive side push with sel 0 for response and 1 for sector data
	task automatic drivePush(input bit sel, input logic [7:0] data);
		if (sel) begin
			i_sectorPush = 1'b1;
			i_sectorByte = data;
			if (dataQ.size() < DATA_FIFO_DEPTH) dataQ.push_back(data);
		end else begin
			i_respPush = 1'b1;
			i_respByte = data;
			if (respQ.size() < RESP_FIFO_DEPTH) respQ.push_back(data);
		end
		@(negedge i_clk);
		i_sectorPush = 1'b0;
		i_respPush   = 1'b0;
	endtask

	task automatic irqRaise(input logic [2:0] code);
		i_irqStrobe = 1'b1;
		i_irqCode   = code;
		modelFlag   = code;
		@(negedge i_clk);
		i_irqStrobe = 1'b0;
	endtask

	task automatic sampleIn(input cdSample_t l, input cdSample_t r);
		i_sampleStrobe = 1'b1;
		i_cdInL = l;
		i_cdInR = r;
		expL = mixModel(l, volWork.ll, r, volWork.rl);
		expR = mixModel(l, volWork.lr, r, volWork.rr);
		@(negedge i_clk);
		i_sampleStrobe = 1'b0;
		checkVal("o_CDRomOutL", o_CDRomOutL, expL);
		checkVal("o_CDRomOutR", o_CDRomOutR, expR);
		checkVal("o_outputL", o_outputL, 1'b1);
		checkVal("o_outputR", o_outputR, 1'b1);
		@(negedge i_clk);
		checkVal("o_outputL", o_outputL, 1'b0);
		checkVal("o_outputR", o_outputR, 1'b0);
	endtask

	// Pending volumes through indices 2 and 3 with optional apply
	task automatic setVolumes(input cdVolume_t v, input bit apply);
		busWrite(ADR_STATUS, 8'd2);
		busWrite(ADR_PARAM, v.ll);
		busWrite(ADR_EXTRA, v.lr);
		busWrite(ADR_STATUS, 8'd3);
		busWrite(ADR_CMD, v.rr);
		busWrite(ADR_PARAM, v.rl);
		busWrite(ADR_EXTRA, apply ? 8'h20 : 8'h00);
	endtask

	// Run length bound
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all tests finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		logic [7:0] got;
		logic [7:0] en;
		cdVolume_t  v;
		cdSample_t  prevL;
		cdSample_t  prevR;
		i_clk = 1'b0;
		i_nrst = 1'b0;
		i_CDROM_CS = 1'b0;
		i_write = 1'b0;
		i_adr = 2'd0;
		i_dataIn = 8'h00;
		i_paramPop = 1'b0;
		i_respPush = 1'b0;
		i_respByte = 8'h00;
		i_sectorPush = 1'b0;
		i_sectorByte = 8'h00;
		i_irqStrobe = 1'b0;
		i_irqCode = 3'd0;
		i_sampleStrobe = 1'b0;
		i_cdInL = '0;
		i_cdInR = '0;
		modelIdx = 2'd0;
		volPend = '0;
		volWork = '0;
		modelEn = 5'd0;
		modelStored = 3'd0;
		modelFlag = 3'd0;
		lastData = 8'h00;
		expL = '0;
		expR = '0;
		lcgState = 32'h1f77_0620;
		passCnt = 0;
		failCnt = 0;
		failStart = 0;
		repeat (RST_CYCLES) @(negedge i_clk);
		i_nrst = 1'b1;

		// Status after reset and index readback
		readCheck(ADR_STATUS, "status", got);
		for (int i = 0; i < 4; i++) begin
			busWrite(ADR_STATUS, 8'(i));
			readCheck(ADR_STATUS, "status", got);
		end
		busWrite(ADR_STATUS, 8'd0);
		endTest("Index and status");

		// Parameter bytes out in order
		for (int i = 0; i < 8; i++) begin
			busWrite(ADR_PARAM, randByte());
		end
		checkVal("o_paramEmpty", o_paramEmpty, 1'b0);
		while (paramQ.size() != 0) begin
			checkVal("o_paramByte", o_paramByte, paramQ[0]);
			i_paramPop = 1'b1;
			@(negedge i_clk);
			i_paramPop = 1'b0;
			void'(paramQ.pop_front());
		end
		checkVal("o_paramEmpty", o_paramEmpty, 1'b1);
		for (int i = 0; i < PARAM_FIFO_DEPTH; i++) begin
			busWrite(ADR_PARAM, randByte());
		end
		readCheck(ADR_STATUS, "status", got);
		checkVal("status bit 4", got[4], 1'b0);
		// Parameter clear through the acknowledge register
		busWrite(ADR_STATUS, 8'd1);
		busWrite(ADR_EXTRA, 8'h40);
		checkVal("o_paramEmpty", o_paramEmpty, 1'b1);
		busWrite(ADR_STATUS, 8'd0);
		endTest("Parameter FIFO");

		checkVal("o_cmdStrobe", o_cmdStrobe, 1'b0);
		got = randByte();
		busWrite(ADR_CMD, got);
		checkVal("o_cmdStrobe", o_cmdStrobe, 1'b1);
		checkVal("o_cmdByte", o_cmdByte, got);
		@(negedge i_clk);
		checkVal("o_cmdStrobe", o_cmdStrobe, 1'b0);
		endTest("Command strobe");

		// Response and sector data in order followed by the empty cases
		for (int i = 0; i < 6; i++) begin
			drivePush(1'b0, randByte());
		end
		for (int i = 0; i < 10; i++) begin
			drivePush(1'b1, randByte());
		end
		readCheck(ADR_STATUS, "status", got);
		while (respQ.size() != 0) begin
			readCheck(ADR_CMD, "response byte", got);
		end
		readCheck(ADR_STATUS, "status", got);
		readCheck(ADR_CMD, "empty response byte", got);
		while (dataQ.size() != 0) begin
			readCheck(ADR_PARAM, "data byte", got);
		end
		readCheck(ADR_STATUS, "status", got);
		readCheck(ADR_PARAM, "repeated data byte", got);
		readCheck(ADR_PARAM, "repeated data byte", got);
		endTest("Response and data FIFOs");

		// Every code under two enable masks
		for (int e = 0; e < 2; e++) begin
			en = randByte();
			en[4:0] = (e == 0) ? 5'b00101 : 5'b11010;
			busWrite(ADR_STATUS, 8'd1);
			busWrite(ADR_PARAM, en);
			busWrite(ADR_STATUS, 8'd0);
			readCheck(ADR_EXTRA, "interrupt enable", got);
			busWrite(ADR_STATUS, 8'd1);
			for (int c = 0; c < 8; c++) begin
				irqRaise(3'(c));
				checkVal("o_irq", o_irq, |(modelFlag & modelEn[2:0]));
				readCheck(ADR_EXTRA, "interrupt flag", got);
				busWrite(ADR_EXTRA, 8'h07);
				checkVal("o_irq", o_irq, 1'b0);
			end
		end
		busWrite(ADR_STATUS, 8'd0);
		endTest("Interrupts");

		// Zero working volumes give silence
		sampleIn(randWord(), randWord());
		for (int i = 0; i < 8; i++) begin
			v = (i < 2) ? 32'hFFFF_FFFF : {randByte(), randByte(), randByte(), randByte()};
			setVolumes(v, 1'b1);
			if (i == 0) begin
				sampleIn(16'sh7FFF, 16'sh7FFF);
			end else if (i == 1) begin
				sampleIn(16'sh8000, 16'sh8000);
			end else begin
				sampleIn(randWord(), randWord());
			end
		end
		// Pending volumes alone change nothing
		prevL = expL;
		prevR = expR;
		setVolumes({randByte(), randByte(), randByte(), randByte()}, 1'b0);
		sampleIn(i_cdInL, i_cdInR);
		checkVal("o_CDRomOutL", o_CDRomOutL, prevL);
		checkVal("o_CDRomOutR", o_CDRomOutR, prevR);
		endTest("Mixer");

		$display("Checks passed %0d, failed %0d", passCnt, failCnt);
		if (failCnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== CDRom.f ====
verilog/cdPkg.sv
verilog/cdFifoIf.sv
verilog/cdByteFifo.sv
verilog/cdRegControl.sv
verilog/cdVolumeMixer.sv
verilog/CDRom.sv
test/tbCDRom.sv

// ==== Bender.yml ====
package:
  name: cdrom

sources:
  - verilog/cdPkg.sv
  - verilog/cdFifoIf.sv
  - verilog/cdByteFifo.sv
  - verilog/cdRegControl.sv
  - verilog/cdVolumeMixer.sv
  - verilog/CDRom.sv
  - target: test
    files:
      - test/tbCDRom.sv
